// File: rtl/proc_pkg.sv
// ----------------------------------------
// processor package
// widths, RV32 encodings, CSR numbers and decode enums
// ----------------------------------------
`default_nettype none

package proc_pkg;

  // ----------------------------------------
  // widths and constants
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // first fetch address out of reset
  localparam logic [xlen-1:0] reset_vector = 32'h0000_0200;

  // major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  // funct3 values
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_bne     = 3'b001;
  // csrw is csrrw with rd x0, csrr is csrrs with rs1 x0
  localparam logic [2:0] f3_csrrw   = 3'b001;
  localparam logic [2:0] f3_csrrs   = 3'b010;

  // funct7 values for reg-reg ops
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // manager CSR numbers
  localparam logic [11:0] csr_proc2mngr = 12'h7c0;
  localparam logic [11:0] csr_mngr2proc = 12'hfc0;

  // ----------------------------------------
  // enum types
  typedef enum logic [3:0] {
    op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu, op_sra,
    op_srl, op_sll, op_addi, op_bne, op_csrr, op_csrw, op_inval
  } inst_op_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu,
    alu_sra, alu_srl, alu_sll, alu_cp0, alu_cp1
  } alu_fn_t;

  typedef enum logic [1:0] {
    op2_rf, op2_imm, op2_mngr
  } op2_sel_t;

  typedef enum logic [0:0] {
    pc_plus4, pc_branch
  } pc_sel_t;

endpackage

`default_nettype wire

// File: rtl/proc_regfile.sv
// ----------------------------------------
// register file
// 32 x 32, two combinational reads, one write, x0 is zero
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_regfile (
  input  logic                            clk,
  input  logic [proc_pkg::reg_addr_w-1:0] raddr0,
  input  logic [proc_pkg::reg_addr_w-1:0] raddr1,
  input  logic [proc_pkg::reg_addr_w-1:0] waddr,
  input  logic                            wen,
  input  logic [proc_pkg::xlen-1:0]       wdata,
  output logic [proc_pkg::xlen-1:0]       rdata0,
  output logic [proc_pkg::xlen-1:0]       rdata1
);

  import proc_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  // write at the end of W, x0 never written
  always_ff @(posedge clk) begin
    if (wen && waddr != '0)
      regs[waddr] <= wdata;
  end

  // x0 reads as zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire

// File: rtl/proc_alu.sv
// ----------------------------------------
// ALU
// reg-reg functions, copies and branch compare
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_alu (
  input  logic [proc_pkg::xlen-1:0] in0,
  input  logic [proc_pkg::xlen-1:0] in1,
  input  proc_pkg::alu_fn_t         fn,
  output logic [proc_pkg::xlen-1:0] out,
  output logic                      eq
);

  import proc_pkg::*;

  // shift amount from the low five bits
  logic [4:0] shamt;
  assign shamt = in1[4:0];

  always_comb begin
    case (fn)
      alu_add:  out = in0 + in1;
      alu_sub:  out = in0 - in1;
      alu_and:  out = in0 & in1;
      alu_or:   out = in0 | in1;
      alu_xor:  out = in0 ^ in1;
      // set less than, signed then unsigned
      alu_slt:  out = {31'd0, $signed(in0) < $signed(in1)};
      alu_sltu: out = {31'd0, in0 < in1};
      alu_sra:  out = $unsigned($signed(in0) >>> shamt);
      alu_srl:  out = in0 >> shamt;
      alu_sll:  out = in0 << shamt;
      // straight copies for csrw and csrr
      alu_cp0:  out = in0;
      alu_cp1:  out = in1;
      default:  out = '0;
    endcase
  end

  // bne condition
  assign eq = (in0 == in1);

endmodule

`default_nettype wire

// File: rtl/proc_ctrl.sv
// ----------------------------------------
// pipeline control unit
// decode, valid bits, stall and squash, stream handshakes
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  // instruction memory streams
  output logic                         imem_req_val,
  input  logic                         imem_resp_val,
  output logic                         imem_resp_rdy,
  output logic                         imem_resp_drop,
  // manager ports
  input  logic                         mngr2proc_val,
  output logic                         mngr2proc_rdy,
  output logic                         proc2mngr_val,
  input  logic                         proc2mngr_rdy,
  output logic                         commit_inst,
  // controls to datapath
  output logic                         reg_en_f,
  output logic                         reg_en_d,
  output logic                         reg_en_x,
  output logic                         reg_en_m,
  output logic                         reg_en_w,
  output proc_pkg::pc_sel_t            pc_sel_f,
  output proc_pkg::op2_sel_t           op2_sel_d,
  output proc_pkg::alu_fn_t            alu_fn_x,
  output logic                         rf_wen_w,
  output logic [proc_pkg::reg_addr_w-1:0] rf_waddr_w,
  // status from datapath
  input  logic [proc_pkg::xlen-1:0]    inst_d,
  input  logic                         br_cond_eq_x
);

  import proc_pkg::*;

  // stage valid bits
  logic val_f, val_d, val_x, val_m, val_w;
  // stalls raised by a stage, stalls in effect, squashes
  logic ostall_f, ostall_d, ostall_w;
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic osquash_x, squash_f, squash_d;
  logic next_val_f, next_val_d, next_val_x, next_val_m;
  // fetch held off for one cycle after reset drops
  logic fetch_en;

  // pipelined control fields
  logic                  rf_wen_x, rf_wen_m, rf_wen_pend_w;
  logic [reg_addr_w-1:0] rf_waddr_x, rf_waddr_m;
  logic                  csrw_x, csrw_m, csrw_w;
  logic                  br_x, pc_redirect_x;

  // ----------------------------------------
  // F stage
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_en <= 1'b0;
      val_f    <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
      if (reg_en_f)
        val_f <= 1'b1;
    end
  end

  assign reg_en_f = fetch_en && (!stall_f || squash_f);
  assign pc_sel_f = pc_redirect_x ? pc_branch : pc_plus4;

  // missing imem response holds F only
  assign ostall_f = val_f && !imem_resp_val;
  assign stall_f  = val_f && (ostall_f || ostall_d || ostall_w);
  assign squash_f = val_f && osquash_x;

  // request goes out before F, response of a squashed fetch is dropped
  assign imem_req_val   = reg_en_f && !reset;
  assign imem_resp_rdy  = reg_en_f;
  assign imem_resp_drop = squash_f;
  assign next_val_f     = val_f && !stall_f && !squash_f;

  // ----------------------------------------
  // D stage
  inst_op_t              op_d;
  logic                  inst_val_d, rs1_en_d, rs2_en_d;
  logic                  rf_wen_d, csrr_d, csrw_d, br_d;
  alu_fn_t               alu_fn_d;
  logic [reg_addr_w-1:0] rs1_d, rs2_d, rd_d;

  assign reg_en_d = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset)
      val_d <= 1'b0;
    else if (reg_en_d)
      val_d <= next_val_f;
  end

  assign rd_d  = inst_d[11:7];
  assign rs1_d = inst_d[19:15];
  assign rs2_d = inst_d[24:20];

  // instruction word to decoded op
  function automatic inst_op_t decode(input logic [xlen-1:0] inst);
    logic [2:0]  f3;
    logic [11:0] csr;
    f3     = inst[14:12];
    csr    = inst[31:20];
    decode = op_inval;
    case (inst[6:0])
      opc_op: begin
        case ({inst[31:25], f3})
          {f7_base, f3_add_sub}: decode = op_add;
          {f7_alt,  f3_add_sub}: decode = op_sub;
          {f7_base, f3_and}:     decode = op_and;
          {f7_base, f3_or}:      decode = op_or;
          {f7_base, f3_xor}:     decode = op_xor;
          {f7_base, f3_slt}:     decode = op_slt;
          {f7_base, f3_sltu}:    decode = op_sltu;
          {f7_alt,  f3_srl_sra}: decode = op_sra;
          {f7_base, f3_srl_sra}: decode = op_srl;
          {f7_base, f3_sll}:     decode = op_sll;
          default:               decode = op_inval;
        endcase
      end
      opc_op_imm:
        if (f3 == f3_add_sub) decode = op_addi;
      opc_branch:
        if (f3 == f3_bne) decode = op_bne;
      opc_system: begin
        // only the two manager CSRs exist
        if (f3 == f3_csrrs && inst[19:15] == '0 && csr == csr_mngr2proc)
          decode = op_csrr;
        else if (f3 == f3_csrrw && inst[11:7] == '0 && csr == csr_proc2mngr)
          decode = op_csrw;
      end
      default: decode = op_inval;
    endcase
  endfunction

  // one row of the control table
  function automatic void cs(input logic val, input logic r1, input logic r2,
                             input alu_fn_t fn, input op2_sel_t sel, input logic wen,
                             input logic rd_csr, input logic wr_csr, input logic br);
    inst_val_d = val;
    rs1_en_d   = r1;
    rs2_en_d   = r2;
    alu_fn_d   = fn;
    op2_sel_d  = sel;
    rf_wen_d   = wen;
    csrr_d     = rd_csr;
    csrw_d     = wr_csr;
    br_d       = br;
  endfunction

  assign op_d = decode(inst_d);

  always_comb begin
    case (op_d)
      //              val   rs1   rs2   alu       op2       wen   csrr  csrw  br
      op_add:  cs(1'b1, 1'b1, 1'b1, alu_add,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_sub:  cs(1'b1, 1'b1, 1'b1, alu_sub,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_and:  cs(1'b1, 1'b1, 1'b1, alu_and,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_or:   cs(1'b1, 1'b1, 1'b1, alu_or,   op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_xor:  cs(1'b1, 1'b1, 1'b1, alu_xor,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_slt:  cs(1'b1, 1'b1, 1'b1, alu_slt,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_sltu: cs(1'b1, 1'b1, 1'b1, alu_sltu, op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_sra:  cs(1'b1, 1'b1, 1'b1, alu_sra,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_srl:  cs(1'b1, 1'b1, 1'b1, alu_srl,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_sll:  cs(1'b1, 1'b1, 1'b1, alu_sll,  op2_rf,   1'b1, 1'b0, 1'b0, 1'b0);
      op_addi: cs(1'b1, 1'b1, 1'b0, alu_add,  op2_imm,  1'b1, 1'b0, 1'b0, 1'b0);
      op_bne:  cs(1'b1, 1'b1, 1'b1, alu_add,  op2_rf,   1'b0, 1'b0, 1'b0, 1'b1);
      op_csrr: cs(1'b1, 1'b0, 1'b0, alu_cp1,  op2_mngr, 1'b1, 1'b1, 1'b0, 1'b0);
      op_csrw: cs(1'b1, 1'b1, 1'b0, alu_cp0,  op2_rf,   1'b0, 1'b0, 1'b1, 1'b0);
      default: cs(1'b0, 1'b0, 1'b0, alu_add,  op2_rf,   1'b0, 1'b0, 1'b0, 1'b0);
    endcase
  end

  // csrr waits in D for the manager value
  logic ostall_mngr2proc_d;
  assign ostall_mngr2proc_d = val_d && csrr_d && !mngr2proc_val;

  // no bypass, so wait until the writer has left W
  logic ostall_x_rs1_d, ostall_m_rs1_d, ostall_w_rs1_d;
  logic ostall_x_rs2_d, ostall_m_rs2_d, ostall_w_rs2_d;
  logic ostall_hazard_d;

  assign ostall_x_rs1_d = rs1_en_d && val_x && rf_wen_x && rs1_d == rf_waddr_x
                          && rf_waddr_x != '0;
  assign ostall_m_rs1_d = rs1_en_d && val_m && rf_wen_m && rs1_d == rf_waddr_m
                          && rf_waddr_m != '0;
  assign ostall_w_rs1_d = rs1_en_d && rf_wen_w && rs1_d == rf_waddr_w
                          && rf_waddr_w != '0;
  assign ostall_x_rs2_d = rs2_en_d && val_x && rf_wen_x && rs2_d == rf_waddr_x
                          && rf_waddr_x != '0;
  assign ostall_m_rs2_d = rs2_en_d && val_m && rf_wen_m && rs2_d == rf_waddr_m
                          && rf_waddr_m != '0;
  assign ostall_w_rs2_d = rs2_en_d && rf_wen_w && rs2_d == rf_waddr_w
                          && rf_waddr_w != '0;

  assign ostall_hazard_d = ostall_x_rs1_d || ostall_m_rs1_d || ostall_w_rs1_d
                        || ostall_x_rs2_d || ostall_m_rs2_d || ostall_w_rs2_d;

  assign ostall_d = val_d && (ostall_mngr2proc_d || ostall_hazard_d);
  assign stall_d  = val_d && (ostall_d || ostall_w);
  assign squash_d = val_d && osquash_x;

  // a squashed csrr must not take a manager value
  assign mngr2proc_rdy = val_d && csrr_d && !stall_d && !squash_d;
  // undecodable words leave as bubbles
  assign next_val_d = val_d && inst_val_d && !stall_d && !squash_d;

  // ----------------------------------------
  // X stage
  assign reg_en_x = !stall_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (reg_en_x) begin
      val_x      <= next_val_d;
      rf_wen_x   <= rf_wen_d;
      rf_waddr_x <= rd_d;
      alu_fn_x   <= alu_fn_d;
      csrw_x     <= csrw_d;
      br_x       <= br_d;
    end
  end

  // bne taken when operands differ
  assign pc_redirect_x = val_x && br_x && !br_cond_eq_x;
  // a stalled X must not squash twice
  assign osquash_x     = val_x && !stall_x && pc_redirect_x;
  assign stall_x       = val_x && ostall_w;
  assign next_val_x    = val_x && !stall_x;

  // ----------------------------------------
  // M stage
  assign reg_en_m = !stall_m;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_m <= 1'b0;
    end else if (reg_en_m) begin
      val_m      <= next_val_x;
      rf_wen_m   <= rf_wen_x;
      rf_waddr_m <= rf_waddr_x;
      csrw_m     <= csrw_x;
    end
  end

  assign stall_m    = val_m && ostall_w;
  assign next_val_m = val_m && !stall_m;

  // ----------------------------------------
  // W stage
  assign reg_en_w = !stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (reg_en_w) begin
      val_w         <= next_val_m;
      rf_wen_pend_w <= rf_wen_m;
      rf_waddr_w    <= rf_waddr_m;
      csrw_w        <= csrw_m;
    end
  end

  assign rf_wen_w = val_w && rf_wen_pend_w;

  // csrw holds W until the manager takes the value
  assign ostall_w      = val_w && csrw_w && !proc2mngr_rdy;
  assign stall_w       = val_w && ostall_w;
  assign proc2mngr_val = val_w && !stall_w && csrw_w;
  assign commit_inst   = val_w && !stall_w;

endmodule

`default_nettype wire

// File: rtl/proc_dpath.sv
// ----------------------------------------
// pipeline datapath
// PC, stage registers, operand select and result pipe
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_dpath (
  input  logic                         clk,
  input  logic                         reset,
  // streams
  output logic [proc_pkg::xlen-1:0]    imem_req_addr,
  input  logic [proc_pkg::xlen-1:0]    imem_resp_data,
  input  logic [proc_pkg::xlen-1:0]    mngr2proc_data,
  output logic [proc_pkg::xlen-1:0]    proc2mngr_data,
  // controls
  input  logic                         reg_en_f,
  input  logic                         reg_en_d,
  input  logic                         reg_en_x,
  input  logic                         reg_en_m,
  input  logic                         reg_en_w,
  input  proc_pkg::pc_sel_t            pc_sel_f,
  input  proc_pkg::op2_sel_t           op2_sel_d,
  input  proc_pkg::alu_fn_t            alu_fn_x,
  input  logic                         rf_wen_w,
  input  logic [proc_pkg::reg_addr_w-1:0] rf_waddr_w,
  // status
  output logic [proc_pkg::xlen-1:0]    inst_d,
  output logic                         br_cond_eq_x
);

  import proc_pkg::*;

  logic [xlen-1:0] pc_f, pc_next_f;
  logic [xlen-1:0] pc_d, imm_i_d, imm_b_d;
  logic [xlen-1:0] rf_rdata0_d, rf_rdata1_d, op2_d;
  logic [xlen-1:0] pc_x, br_imm_x, op1_x, op2_x, br_target_x, alu_out_x;
  logic [xlen-1:0] result_m, result_w;

  // ----------------------------------------
  // F stage
  // next PC is the fetch address sent this cycle
  assign br_target_x   = pc_x + br_imm_x;
  assign pc_next_f     = (pc_sel_f == pc_branch) ? br_target_x : pc_f + 32'd4;
  assign imem_req_addr = pc_next_f;

  // one word below the vector so the first request hits reset_vector
  always_ff @(posedge clk) begin
    if (reset)
      pc_f <= reset_vector - 32'd4;
    else if (reg_en_f)
      pc_f <= pc_next_f;
  end

  // ----------------------------------------
  // D stage
  always_ff @(posedge clk) begin
    if (reg_en_d) begin
      inst_d <= imem_resp_data;
      pc_d   <= pc_f;
    end
  end

  // I-type and B-type immediates
  assign imm_i_d = {{20{inst_d[31]}}, inst_d[31:20]};
  assign imm_b_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};

  proc_regfile rf (
    .clk    (clk),
    .raddr0 (inst_d[19:15]),
    .raddr1 (inst_d[24:20]),
    .waddr  (rf_waddr_w),
    .wen    (rf_wen_w),
    .wdata  (result_w),
    .rdata0 (rf_rdata0_d),
    .rdata1 (rf_rdata1_d)
  );

  // operand 2 source
  always_comb begin
    case (op2_sel_d)
      op2_rf:   op2_d = rf_rdata1_d;
      op2_imm:  op2_d = imm_i_d;
      op2_mngr: op2_d = mngr2proc_data;
      default:  op2_d = '0;
    endcase
  end

  // ----------------------------------------
  // X stage
  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      pc_x     <= pc_d;
      br_imm_x <= imm_b_d;
      op1_x    <= rf_rdata0_d;
      op2_x    <= op2_d;
    end
  end

  proc_alu alu (
    .in0 (op1_x),
    .in1 (op2_x),
    .fn  (alu_fn_x),
    .out (alu_out_x),
    .eq  (br_cond_eq_x)
  );

  // ----------------------------------------
  // M and W stages
  always_ff @(posedge clk) begin
    if (reg_en_m)
      result_m <= alu_out_x;
  end

  always_ff @(posedge clk) begin
    if (reg_en_w)
      result_w <= result_m;
  end

  // csrw result doubles as the manager payload
  assign proc2mngr_data = result_w;

endmodule

`default_nettype wire

// File: rtl/proc_top.sv
// ----------------------------------------
// five-stage pipelined processor
// control unit joined to datapath
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_top (
  input  logic                      clk,
  input  logic                      reset,
  // instruction memory
  output logic                      imem_req_val,
  output logic [proc_pkg::xlen-1:0] imem_req_addr,
  input  logic                      imem_resp_val,
  output logic                      imem_resp_rdy,
  output logic                      imem_resp_drop,
  input  logic [proc_pkg::xlen-1:0] imem_resp_data,
  // manager ports
  input  logic                      mngr2proc_val,
  output logic                      mngr2proc_rdy,
  input  logic [proc_pkg::xlen-1:0] mngr2proc_data,
  output logic                      proc2mngr_val,
  input  logic                      proc2mngr_rdy,
  output logic [proc_pkg::xlen-1:0] proc2mngr_data,
  output logic                      commit_inst
);

  import proc_pkg::*;

  // control to datapath
  logic                  reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w;
  pc_sel_t               pc_sel_f;
  op2_sel_t              op2_sel_d;
  alu_fn_t               alu_fn_x;
  logic                  rf_wen_w;
  logic [reg_addr_w-1:0] rf_waddr_w;
  // datapath status
  logic [xlen-1:0]       inst_d;
  logic                  br_cond_eq_x;

  proc_ctrl ctrl (
    .clk            (clk),
    .reset          (reset),
    .imem_req_val   (imem_req_val),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_drop (imem_resp_drop),
    .mngr2proc_val  (mngr2proc_val),
    .mngr2proc_rdy  (mngr2proc_rdy),
    .proc2mngr_val  (proc2mngr_val),
    .proc2mngr_rdy  (proc2mngr_rdy),
    .commit_inst    (commit_inst),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .reg_en_x       (reg_en_x),
    .reg_en_m       (reg_en_m),
    .reg_en_w       (reg_en_w),
    .pc_sel_f       (pc_sel_f),
    .op2_sel_d      (op2_sel_d),
    .alu_fn_x       (alu_fn_x),
    .rf_wen_w       (rf_wen_w),
    .rf_waddr_w     (rf_waddr_w),
    .inst_d         (inst_d),
    .br_cond_eq_x   (br_cond_eq_x)
  );

  proc_dpath dpath (
    .clk            (clk),
    .reset          (reset),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_data (imem_resp_data),
    .mngr2proc_data (mngr2proc_data),
    .proc2mngr_data (proc2mngr_data),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .reg_en_x       (reg_en_x),
    .reg_en_m       (reg_en_m),
    .reg_en_w       (reg_en_w),
    .pc_sel_f       (pc_sel_f),
    .op2_sel_d      (op2_sel_d),
    .alu_fn_x       (alu_fn_x),
    .rf_wen_w       (rf_wen_w),
    .rf_waddr_w     (rf_waddr_w),
    .inst_d         (inst_d),
    .br_cond_eq_x   (br_cond_eq_x)
  );

endmodule

`default_nettype wire

// File: verif/proc_model.svh
// ----------------------------------------
// ISA reference model and RV32 encoders
// ----------------------------------------
`ifndef PROC_MODEL_SVH
`define PROC_MODEL_SVH

// reg-reg op with its funct7 and funct3
function automatic logic [31:0] enc_rr(input inst_op_t op, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2);
  case (op)
    op_sub:  return {f7_alt,  rs2, rs1, f3_add_sub, rd, opc_op};
    op_and:  return {f7_base, rs2, rs1, f3_and,     rd, opc_op};
    op_or:   return {f7_base, rs2, rs1, f3_or,      rd, opc_op};
    op_xor:  return {f7_base, rs2, rs1, f3_xor,     rd, opc_op};
    op_slt:  return {f7_base, rs2, rs1, f3_slt,     rd, opc_op};
    op_sltu: return {f7_base, rs2, rs1, f3_sltu,    rd, opc_op};
    op_sra:  return {f7_alt,  rs2, rs1, f3_srl_sra, rd, opc_op};
    op_srl:  return {f7_base, rs2, rs1, f3_srl_sra, rd, opc_op};
    op_sll:  return {f7_base, rs2, rs1, f3_sll,     rd, opc_op};
    default: return {f7_base, rs2, rs1, f3_add_sub, rd, opc_op};
  endcase
endfunction

function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
  return {imm, rs1, f3_add_sub, rd, opc_op_imm};
endfunction

// byte offset, bit 0 is implied zero
function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3_bne, off[4:1], off[11], opc_branch};
endfunction

// csrrs rd, mngr2proc, x0
function automatic logic [31:0] enc_csrr(input logic [4:0] rd);
  return {csr_mngr2proc, 5'd0, f3_csrrs, rd, opc_system};
endfunction

// csrrw x0, proc2mngr, rs1
function automatic logic [31:0] enc_csrw(input logic [4:0] rs1);
  return {csr_proc2mngr, rs1, f3_csrrw, 5'd0, opc_system};
endfunction

// architectural result of a reg-reg op or addi
function automatic logic [31:0] isa_result(input inst_op_t op, input logic [31:0] a,
                                           input logic [31:0] b);
  case (op)
    op_sub:  return a - b;
    op_and:  return a & b;
    op_or:   return a | b;
    op_xor:  return a ^ b;
    op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    op_sltu: return (a < b) ? 32'd1 : 32'd0;
    op_sra:  return $signed(a) >>> b[4:0];
    op_srl:  return a >> b[4:0];
    op_sll:  return a << b[4:0];
    default: return a + b;
  endcase
endfunction

// walk the program in order, branches only go forward
task automatic run_model();
  logic [31:0] x [32];
  int pc;
  int mi;
  pc = 0;
  mi = 0;
  for (int r = 0; r < 32; r++)
    x[r] = '0;
  exp_commits = 0;
  while (pc < prog_len) begin
    exp_commits++;
    case (p_op[pc])
      op_csrr: begin
        x[p_rd[pc]] = mngr_vals[mi];
        mi++;
      end
      op_csrw: exp_out.push_back(x[p_rs1[pc]]);
      op_bne:  ;
      op_addi: x[p_rd[pc]] = isa_result(op_add, x[p_rs1[pc]], p_imm[pc]);
      default: x[p_rd[pc]] = isa_result(p_op[pc], x[p_rs1[pc]], x[p_rs2[pc]]);
    endcase
    if (p_op[pc] == op_bne && x[p_rs1[pc]] != x[p_rs2[pc]])
      pc = pc + int'(p_imm[pc] >> 2);
    else
      pc = pc + 1;
  end
  n_mngr = mi;
endtask

`endif

// File: verif/proc_tb.sv
// ----------------------------------------
// processor testbench
// random program checked against the ISA model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_tb;

  import proc_pkg::*;

  localparam int prog_len       = 60;
  localparam int body_start     = 7;
  localparam int tail_start     = prog_len - 7;
  localparam int timeout_cycles = 5000;

  logic            clk = 1'b0;
  logic            reset;
  logic            imem_req_val, imem_resp_val, imem_resp_rdy, imem_resp_drop;
  logic [xlen-1:0] imem_req_addr, imem_resp_data;
  logic            mngr2proc_val, mngr2proc_rdy, proc2mngr_val, proc2mngr_rdy;
  logic [xlen-1:0] mngr2proc_data, proc2mngr_data;
  logic            commit_inst;

  integer seed = 32'h236b_377a;

  // program image, with fields kept for the model
  inst_op_t        p_op      [prog_len];
  logic [4:0]      p_rd      [prog_len];
  logic [4:0]      p_rs1     [prog_len];
  logic [4:0]      p_rs2     [prog_len];
  logic [xlen-1:0] p_imm     [prog_len];
  logic [xlen-1:0] prog_mem  [prog_len];
  logic [xlen-1:0] mngr_vals [prog_len];
  logic [xlen-1:0] exp_out   [$];
  int              exp_commits;
  int              n_mngr;

  // environment state
  logic [xlen-1:0] resp_q [$];
  int   mngr_idx       = 0;
  int   out_idx        = 0;
  int   commits        = 0;
  int   low_cycles     = 0;
  logic first_req_seen = 1'b0;
  int   value_errors   = 0;
  int   proto_errors   = 0;
  int   end_errors     = 0;

  `include "proc_model.svh"

  proc_top uut (
    .clk            (clk),
    .reset          (reset),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_drop (imem_resp_drop),
    .imem_resp_data (imem_resp_data),
    .mngr2proc_val  (mngr2proc_val),
    .mngr2proc_rdy  (mngr2proc_rdy),
    .mngr2proc_data (mngr2proc_data),
    .proc2mngr_val  (proc2mngr_val),
    .proc2mngr_rdy  (proc2mngr_rdy),
    .proc2mngr_data (proc2mngr_data),
    .commit_inst    (commit_inst)
  );

  always #5 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // program words, elsewhere a fill that decodes as invalid
  function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] off;
    off = addr - reset_vector;
    if (addr >= reset_vector && off < prog_len * 4 && off[1:0] == 2'b00)
      return prog_mem[int'(off >> 2)];
    return {addr[31:7] ^ {18'd0, addr[6:0]}, 7'h00};
  endfunction

  // ----------------------------------------
  // random program
  task automatic build_program();
    logic [31:0] r;
    int          kind;
    int          k;
    for (int i = 0; i < prog_len; i++) begin
      r         = $random(seed);
      kind      = rand_below(14);
      p_rd[i]   = 5'(1 + rand_below(7));
      p_rs1[i]  = 5'(1 + rand_below(7));
      p_rs2[i]  = 5'(1 + rand_below(7));
      p_imm[i]  = {{20{r[11]}}, r[11:0]};
      if (i < body_start) begin
        // give x1..x7 a known value first
        p_op[i]  = op_addi;
        p_rd[i]  = 5'(i + 1);
        p_rs1[i] = 5'd0;
      end else if (i >= tail_start) begin
        p_op[i]  = op_csrw;
        p_rs1[i] = 5'(i - tail_start + 1);
      end else if (kind < 10) begin
        p_op[i] = inst_op_t'(4'(kind));
      end else if (kind < 12) begin
        p_op[i] = op_addi;
      end else if (kind == 12) begin
        p_op[i] = op_csrr;
      end else begin
        // forward 1 to 4 words, never past the csrw tail
        p_op[i]  = op_bne;
        k        = 1 + rand_below((tail_start - i < 4) ? tail_start - i : 4);
        p_imm[i] = 32'(k * 4);
        // equal operands now and then for the not-taken path
        if (rand_below(3) == 0)
          p_rs2[i] = p_rs1[i];
      end
      case (p_op[i])
        op_addi: prog_mem[i] = enc_addi(p_rd[i], p_rs1[i], p_imm[i][11:0]);
        op_bne:  prog_mem[i] = enc_bne(p_rs1[i], p_rs2[i], p_imm[i][12:0]);
        op_csrr: prog_mem[i] = enc_csrr(p_rd[i]);
        op_csrw: prog_mem[i] = enc_csrw(p_rs1[i]);
        default: prog_mem[i] = enc_rr(p_op[i], p_rd[i], p_rs1[i], p_rs2[i]);
      endcase
      mngr_vals[i] = $random(seed);
    end
  endtask

  // random stream levels for one cycle
  task automatic drive_inputs();
    imem_resp_val  = resp_q.size() > 0 && rand_below(2) == 0;
    imem_resp_data = (resp_q.size() > 0) ? resp_q[0] : '0;
    mngr2proc_val  = rand_below(2) == 0;
    mngr2proc_data = (mngr_idx < n_mngr) ? mngr_vals[mngr_idx] : 32'hbad0_0bad;
    proc2mngr_rdy  = rand_below(4) != 0;
  endtask

  // ----------------------------------------
  // monitor, sampled mid-cycle
  always @(negedge clk) begin
    // quiet outputs in reset and the first cycle after it
    if (reset || low_cycles == 0) begin
      assert (!imem_req_val && !mngr2proc_rdy && !proc2mngr_val && !commit_inst
              && !imem_resp_drop)
      else begin
        proto_errors++;
        $display("time %0t: a stream output was high during or right after reset", $time);
      end
    end
    if (!reset)
      low_cycles++;
    if (imem_req_val && !first_req_seen) begin
      first_req_seen = 1'b1;
      assert (imem_req_addr == reset_vector)
      else begin
        value_errors++;
        $display("Fail time %0t imem_req_addr got %h expected %h", $time,
                 imem_req_addr, reset_vector);
      end
    end
    // imem: pop on consume, or drop a squashed fetch still waiting
    if (imem_resp_val && imem_resp_rdy)
      resp_q.delete(0);
    else if (imem_resp_drop && imem_resp_rdy && resp_q.size() > 0)
      resp_q.delete(0);
    if (imem_req_val)
      resp_q.push_back(mem_word(imem_req_addr));
    if (mngr2proc_val && mngr2proc_rdy) begin
      assert (mngr_idx < n_mngr)
      else begin
        proto_errors++;
        $display("time %0t: mngr2proc value taken with no csrr left in the program", $time);
      end
      mngr_idx++;
    end
    if (proc2mngr_val) begin
      assert (proc2mngr_rdy && commit_inst)
      else begin
        proto_errors++;
        $display("time %0t: proc2mngr_val high without ready or without a commit", $time);
      end
    end
    if (proc2mngr_val && proc2mngr_rdy) begin
      assert (out_idx < exp_out.size())
      else begin
        proto_errors++;
        $display("time %0t: proc2mngr transfer beyond the expected outputs", $time);
      end
      if (out_idx < exp_out.size()) begin
        assert (proc2mngr_data == exp_out[out_idx])
        else begin
          value_errors++;
          $display("Fail time %0t proc2mngr_data got %h expected %h", $time,
                   proc2mngr_data, exp_out[out_idx]);
        end
      end
      out_idx++;
    end
    if (commit_inst) begin
      commits++;
      assert (commits <= exp_commits)
      else begin
        proto_errors++;
        $display("time %0t: more commits than the program executes", $time);
      end
    end
  end

  // ----------------------------------------
  // main sequence
  initial begin
    int cycles;
    reset          = 1'b1;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    mngr2proc_val  = 1'b0;
    mngr2proc_data = '0;
    proc2mngr_rdy  = 1'b0;
    build_program();
    run_model();
    repeat (16) @(posedge clk);
    #1;
    reset  = 1'b0;
    cycles = 0;
    while ((out_idx < exp_out.size() || commits < exp_commits) && cycles < timeout_cycles) begin
      drive_inputs();
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles >= timeout_cycles) begin
      end_errors++;
      $display("timeout: program did not finish within %0d cycles", timeout_cycles);
    end else begin
      // wrong-path and fill words keep flowing, none may commit
      for (int i = 0; i < 20; i++) begin
        drive_inputs();
        @(posedge clk);
        #1;
      end
    end
    assert (commits == exp_commits)
    else begin
      end_errors++;
      $display("Fail time %0t commit_inst count got %0d expected %0d", $time,
               commits, exp_commits);
    end
    assert (mngr_idx == n_mngr)
    else begin
      end_errors++;
      $display("Fail time %0t mngr2proc transfers got %0d expected %0d", $time,
               mngr_idx, n_mngr);
    end
    assert (out_idx == exp_out.size())
    else begin
      end_errors++;
      $display("Fail time %0t proc2mngr transfers got %0d expected %0d", $time,
               out_idx, exp_out.size());
    end
    $display("error counts: value %0d, protocol %0d, completion %0d",
             value_errors, proto_errors, end_errors);
    if (value_errors + proto_errors + end_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verif
rtl/proc_pkg.sv
rtl/proc_regfile.sv
rtl/proc_alu.sv
rtl/proc_ctrl.sv
rtl/proc_dpath.sv
rtl/proc_top.sv
verif/proc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module proc_tb -o proc_sim
./obj_dir/proc_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "Testbench passed" sim.log; then
  exit 0
fi
exit 1
